/* source/mips_macros.svh */
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// data and instruction word width
`define MIPS_XLEN 32

// architectural registers
`define MIPS_REG_COUNT 32

// jal writes its return address here
`define MIPS_LINK_REG 31

// word address bits on each memory port, byte address bits [11:2]
`define MIPS_MEM_AW 10

`endif

/* source/mips_pkg.sv */
`include "mips_macros.svh"

package mips_pkg;

    typedef logic [`MIPS_XLEN-1:0] word_t;
    typedef logic [$clog2(`MIPS_REG_COUNT)-1:0] reg_idx_t;
    typedef logic [`MIPS_MEM_AW-1:0] mem_addr_t;
    typedef logic [$clog2(`MIPS_XLEN)-1:0] shamt_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_t;

    // lui uses the upper form
    typedef enum logic [1:0] {EXT_ZERO, EXT_SIGN, EXT_UPPER} ext_op_t;

    typedef enum logic [1:0] {NPC_PC4, NPC_BRANCH, NPC_JUMP} npc_op_t;

    typedef enum logic [2:0] {WB_ALU, WB_MEM, WB_LINK, WB_IMM} wb_sel_t;

    typedef enum logic [1:0] {WA_RD, WA_RT, WA_LINK} wa_sel_t;

    typedef enum logic [3:0] {
        FETCH, DECODE,
        ALU_EXE, ALU_WB,
        MEM_ADDR, MEM_STORE, MEM_LOAD, MEM_WB,
        BRANCH, JAL_EXE, LUI_WB
    } state_t;

endpackage

/* source/mips_alu.sv */
`timescale 1ns/1ps

`include "mips_macros.svh"

module mips_alu (
    input  mips_pkg::word_t   op_a,
    input  mips_pkg::word_t   op_b,
    input  mips_pkg::shamt_t  shamt,
    input  mips_pkg::alu_op_t alu_op,
    output mips_pkg::word_t   result,
    output logic              zero,
    output logic              overflow
);
    import mips_pkg::*;

    localparam int MSB = `MIPS_XLEN - 1;

    word_t sum;
    word_t diff;
    logic  add_ovf;
    logic  sub_ovf;

    assign sum  = op_a + op_b;
    assign diff = op_a - op_b;

    // same-sign add or mixed-sign sub flips the sign bit
    assign add_ovf = (op_a[MSB] == op_b[MSB]) && (sum[MSB] != op_a[MSB]);
    assign sub_ovf = (op_a[MSB] != op_b[MSB]) && (diff[MSB] != op_a[MSB]);

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = sum;
            ALU_SUB:  result = diff;
            ALU_AND:  result = op_a & op_b;
            ALU_OR:   result = op_a | op_b;
            ALU_XOR:  result = op_a ^ op_b;
            ALU_NOR:  result = ~(op_a | op_b);
            ALU_SLT:  result = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU: result = word_t'(op_a < op_b);
            // shifts act on rt, which arrives as op_b
            ALU_SLL:  result = op_b << shamt;
            ALU_SRL:  result = op_b >> shamt;
            ALU_SRA:  result = word_t'($signed(op_b) >>> shamt);
            default:  result = sum;
        endcase
    end

    assign zero     = (op_a == op_b);
    assign overflow = ((alu_op == ALU_ADD) && add_ovf) ||
                      ((alu_op == ALU_SUB) && sub_ovf);

endmodule

/* source/mips_regfile.sv */
`timescale 1ns/1ps

`include "mips_macros.svh"

module mips_regfile (
    input  logic               clk,
    input  logic               rst,
    input  logic               we,
    input  mips_pkg::reg_idx_t raddr_a,
    input  mips_pkg::reg_idx_t raddr_b,
    input  mips_pkg::reg_idx_t waddr,
    input  mips_pkg::word_t    wdata,
    output mips_pkg::word_t    rdata_a,
    output mips_pkg::word_t    rdata_b
);
    import mips_pkg::*;

    word_t regs [`MIPS_REG_COUNT];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            // r0 never written, so it keeps its reset value
            regs[waddr] <= wdata;
        end
    end

    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

endmodule

/* source/mips_datapath.sv */
`timescale 1ns/1ps

`include "mips_macros.svh"

module mips_datapath (
    input  logic                clk,
    input  logic                rst,
    input  logic                ir_we,
    input  logic                pc_we,
    input  logic                op2_imm,
    input  logic                shift_var,
    input  mips_pkg::ext_op_t   ext_op,
    input  mips_pkg::npc_op_t   npc_op,
    input  mips_pkg::wb_sel_t   wb_sel,
    input  mips_pkg::wa_sel_t   wa_sel,
    input  mips_pkg::word_t     imem_rdata,
    input  mips_pkg::word_t     dmem_rdata,
    input  mips_pkg::word_t     rf_rdata_a,
    input  mips_pkg::word_t     rf_rdata_b,
    input  mips_pkg::word_t     result,
    output mips_pkg::word_t     instr,
    output mips_pkg::mem_addr_t imem_addr,
    output mips_pkg::mem_addr_t dmem_addr,
    output mips_pkg::word_t     dmem_wdata,
    output mips_pkg::reg_idx_t  rf_raddr_a,
    output mips_pkg::reg_idx_t  rf_raddr_b,
    output mips_pkg::reg_idx_t  rf_waddr,
    output mips_pkg::word_t     rf_wdata,
    output mips_pkg::word_t     op_a,
    output mips_pkg::word_t     op_b,
    output mips_pkg::shamt_t    shamt
);
    import mips_pkg::*;

    word_t ir;
    word_t pc;
    word_t pc_plus4;
    word_t npc;
    word_t imm_ext;
    word_t a_reg;
    word_t b_reg;
    word_t alu_out;
    word_t mdr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ir      <= '0;
            pc      <= '0;
            a_reg   <= '0;
            b_reg   <= '0;
            alu_out <= '0;
            mdr     <= '0;
        end else begin
            if (ir_we) begin
                ir <= imem_rdata;
            end
            if (pc_we) begin
                pc <= npc;
            end
            // operands stay stable because only the last state writes back
            a_reg   <= rf_rdata_a;
            b_reg   <= rf_rdata_b;
            alu_out <= result;
            mdr     <= dmem_rdata;
        end
    end

    always_comb begin
        case (ext_op)
            EXT_ZERO:  imm_ext = {16'h0000, ir[15:0]};
            EXT_UPPER: imm_ext = {ir[15:0], 16'h0000};
            default:   imm_ext = {{16{ir[15]}}, ir[15:0]};
        endcase
    end

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (npc_op)
            NPC_BRANCH: npc = pc_plus4 + {imm_ext[29:0], 2'b00};
            NPC_JUMP:   npc = {pc_plus4[31:28], ir[25:0], 2'b00};
            default:    npc = pc_plus4;
        endcase
    end

    always_comb begin
        case (wa_sel)
            WA_RD:   rf_waddr = ir[15:11];
            WA_LINK: rf_waddr = reg_idx_t'(`MIPS_LINK_REG);
            default: rf_waddr = ir[20:16];
        endcase
    end

    always_comb begin
        case (wb_sel)
            WB_MEM:  rf_wdata = mdr;
            WB_LINK: rf_wdata = pc_plus4;
            WB_IMM:  rf_wdata = imm_ext;
            default: rf_wdata = alu_out;
        endcase
    end

    assign instr      = ir;
    assign imem_addr  = pc[`MIPS_MEM_AW+1:2];
    assign dmem_addr  = alu_out[`MIPS_MEM_AW+1:2];
    assign dmem_wdata = b_reg;
    assign rf_raddr_a = ir[25:21];
    assign rf_raddr_b = ir[20:16];
    assign op_a       = a_reg;
    assign op_b       = op2_imm ? imm_ext : b_reg;
    // variable shifts take the amount from rs
    assign shamt      = shift_var ? a_reg[4:0] : ir[10:6];

endmodule

/* source/mips_control.sv */
`timescale 1ns/1ps

module mips_control (
    input  logic              clk,
    input  logic              rst,
    input  mips_pkg::word_t   instr,
    input  logic              zero,
    input  logic              overflow,
    output logic              ir_we,
    output logic              pc_we,
    output logic              rf_we,
    output logic              dmem_we,
    output logic              op2_imm,
    output logic              shift_var,
    output mips_pkg::alu_op_t alu_op,
    output mips_pkg::ext_op_t ext_op,
    output mips_pkg::npc_op_t npc_op,
    output mips_pkg::wb_sel_t wb_sel,
    output mips_pkg::wa_sel_t wa_sel,
    output logic              integer_overflow
);
    import mips_pkg::*;

    state_t state;
    state_t state_nxt;
    logic   is_alu;
    logic   is_lw;
    logic   is_sw;
    logic   is_beq;
    logic   is_jal;
    logic   is_lui;
    logic   ovf_check;
    logic   unsupported;

    // decode depends only on the instruction register
    always_comb begin
        is_alu    = 1'b0;
        is_lw     = 1'b0;
        is_sw     = 1'b0;
        is_beq    = 1'b0;
        is_jal    = 1'b0;
        is_lui    = 1'b0;
        ovf_check = 1'b0;
        shift_var = 1'b0;
        op2_imm   = 1'b0;
        alu_op    = ALU_ADD;
        ext_op    = EXT_SIGN;
        wa_sel    = WA_RT;
        case (instr[31:26])
            6'h00: begin
                is_alu = 1'b1;
                wa_sel = WA_RD;
                case (instr[5:0])
                    6'h20: ovf_check = 1'b1;
                    6'h21: alu_op = ALU_ADD;
                    6'h22: begin
                        alu_op    = ALU_SUB;
                        ovf_check = 1'b1;
                    end
                    6'h23: alu_op = ALU_SUB;
                    6'h24: alu_op = ALU_AND;
                    6'h25: alu_op = ALU_OR;
                    6'h26: alu_op = ALU_XOR;
                    6'h27: alu_op = ALU_NOR;
                    6'h2a: alu_op = ALU_SLT;
                    6'h2b: alu_op = ALU_SLTU;
                    6'h00: alu_op = ALU_SLL;
                    6'h02: alu_op = ALU_SRL;
                    6'h03: alu_op = ALU_SRA;
                    6'h04: begin
                        alu_op    = ALU_SLL;
                        shift_var = 1'b1;
                    end
                    6'h06: begin
                        alu_op    = ALU_SRL;
                        shift_var = 1'b1;
                    end
                    6'h07: begin
                        alu_op    = ALU_SRA;
                        shift_var = 1'b1;
                    end
                    default: is_alu = 1'b0;
                endcase
            end
            6'h08: begin
                is_alu    = 1'b1;
                op2_imm   = 1'b1;
                ovf_check = 1'b1;
            end
            6'h09: begin
                is_alu  = 1'b1;
                op2_imm = 1'b1;
            end
            6'h0a: begin
                is_alu  = 1'b1;
                op2_imm = 1'b1;
                alu_op  = ALU_SLT;
            end
            6'h0b: begin
                is_alu  = 1'b1;
                op2_imm = 1'b1;
                alu_op  = ALU_SLTU;
            end
            6'h0c: begin
                is_alu  = 1'b1;
                op2_imm = 1'b1;
                alu_op  = ALU_AND;
                ext_op  = EXT_ZERO;
            end
            6'h0d: begin
                is_alu  = 1'b1;
                op2_imm = 1'b1;
                alu_op  = ALU_OR;
                ext_op  = EXT_ZERO;
            end
            6'h0e: begin
                is_alu  = 1'b1;
                op2_imm = 1'b1;
                alu_op  = ALU_XOR;
                ext_op  = EXT_ZERO;
            end
            6'h0f: begin
                is_lui = 1'b1;
                ext_op = EXT_UPPER;
            end
            6'h23: begin
                is_lw   = 1'b1;
                op2_imm = 1'b1;
            end
            6'h2b: begin
                is_sw   = 1'b1;
                op2_imm = 1'b1;
            end
            6'h04: begin
                is_beq = 1'b1;
                alu_op = ALU_SUB;
            end
            6'h03: begin
                is_jal = 1'b1;
                wa_sel = WA_LINK;
            end
            default: ;
        endcase
    end

    assign unsupported = !(is_alu || is_lw || is_sw || is_beq || is_jal || is_lui);

    always_comb begin
        case (state)
            FETCH: state_nxt = DECODE;
            DECODE: begin
                if (is_alu) begin
                    state_nxt = ALU_EXE;
                end else if (is_lw || is_sw) begin
                    state_nxt = MEM_ADDR;
                end else if (is_beq) begin
                    state_nxt = BRANCH;
                end else if (is_jal) begin
                    state_nxt = JAL_EXE;
                end else if (is_lui) begin
                    state_nxt = LUI_WB;
                end else begin
                    state_nxt = FETCH;
                end
            end
            ALU_EXE:  state_nxt = ALU_WB;
            MEM_ADDR: state_nxt = is_sw ? MEM_STORE : MEM_LOAD;
            MEM_LOAD: state_nxt = MEM_WB;
            default:  state_nxt = FETCH;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= FETCH;
        end else begin
            state <= state_nxt;
        end
    end

    assign ir_we   = (state == FETCH);
    assign dmem_we = (state == MEM_STORE);
    assign rf_we   = (state == ALU_WB) || (state == MEM_WB) ||
                     (state == JAL_EXE) || (state == LUI_WB);
    // last state of every instruction, unsupported ones end in decode
    assign pc_we   = rf_we || (state == MEM_STORE) || (state == BRANCH) ||
                     (state == DECODE && unsupported);

    always_comb begin
        case (state)
            MEM_WB:  wb_sel = WB_MEM;
            JAL_EXE: wb_sel = WB_LINK;
            LUI_WB:  wb_sel = WB_IMM;
            default: wb_sel = WB_ALU;
        endcase
    end

    always_comb begin
        if (state == BRANCH && zero) begin
            npc_op = NPC_BRANCH;
        end else if (state == JAL_EXE) begin
            npc_op = NPC_JUMP;
        end else begin
            npc_op = NPC_PC4;
        end
    end

    // set by a trapping op, cleared once the next instruction is fetched
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            integer_overflow <= 1'b0;
        end else if (state == ALU_EXE && ovf_check && overflow) begin
            integer_overflow <= 1'b1;
        end else if (state == FETCH) begin
            integer_overflow <= 1'b0;
        end
    end

endmodule

/* source/mips_core.sv */
`timescale 1ns/1ps

module mips_core (
    input  logic                clk,
    input  logic                rst,
    input  mips_pkg::word_t     imem_rdata,
    input  mips_pkg::word_t     dmem_rdata,
    output mips_pkg::mem_addr_t imem_addr,
    output mips_pkg::mem_addr_t dmem_addr,
    output mips_pkg::word_t     dmem_wdata,
    output logic                dmem_we,
    output logic                integer_overflow
);
    import mips_pkg::*;

    word_t    instr;
    word_t    op_a;
    word_t    op_b;
    word_t    result;
    word_t    rf_rdata_a;
    word_t    rf_rdata_b;
    word_t    rf_wdata;
    reg_idx_t rf_raddr_a;
    reg_idx_t rf_raddr_b;
    reg_idx_t rf_waddr;
    shamt_t   shamt;
    alu_op_t  alu_op;
    ext_op_t  ext_op;
    npc_op_t  npc_op;
    wb_sel_t  wb_sel;
    wa_sel_t  wa_sel;
    logic     ir_we;
    logic     pc_we;
    logic     rf_we;
    logic     op2_imm;
    logic     shift_var;
    logic     zero;
    logic     overflow;

    mips_control i_control (
        .clk(clk), .rst(rst),
        .instr(instr), .zero(zero), .overflow(overflow),
        .ir_we(ir_we), .pc_we(pc_we), .rf_we(rf_we), .dmem_we(dmem_we),
        .op2_imm(op2_imm), .shift_var(shift_var),
        .alu_op(alu_op), .ext_op(ext_op), .npc_op(npc_op),
        .wb_sel(wb_sel), .wa_sel(wa_sel),
        .integer_overflow(integer_overflow)
    );

    mips_datapath i_datapath (
        .clk(clk), .rst(rst),
        .ir_we(ir_we), .pc_we(pc_we), .op2_imm(op2_imm), .shift_var(shift_var),
        .ext_op(ext_op), .npc_op(npc_op), .wb_sel(wb_sel), .wa_sel(wa_sel),
        .imem_rdata(imem_rdata), .dmem_rdata(dmem_rdata),
        .rf_rdata_a(rf_rdata_a), .rf_rdata_b(rf_rdata_b), .result(result),
        .instr(instr), .imem_addr(imem_addr),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
        .rf_raddr_a(rf_raddr_a), .rf_raddr_b(rf_raddr_b),
        .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
        .op_a(op_a), .op_b(op_b), .shamt(shamt)
    );

    mips_regfile i_regfile (
        .clk(clk), .rst(rst), .we(rf_we),
        .raddr_a(rf_raddr_a), .raddr_b(rf_raddr_b),
        .waddr(rf_waddr), .wdata(rf_wdata),
        .rdata_a(rf_rdata_a), .rdata_b(rf_rdata_b)
    );

    mips_alu i_alu (
        .op_a(op_a), .op_b(op_b), .shamt(shamt), .alu_op(alu_op),
        .result(result), .zero(zero), .overflow(overflow)
    );

endmodule

/* sim/mips_core_sva.sv */
`timescale 1ns/1ps

module mips_core_sva (
    input logic                clk,
    input logic                rst,
    input logic                dmem_we,
    input mips_pkg::mem_addr_t imem_addr,
    input logic                integer_overflow
);

    int fail_count = 0;

    // a store occupies exactly one state
    store_one_cycle: assert property (
        @(posedge clk) disable iff (rst) dmem_we |=> !dmem_we
    ) else begin
        fail_count++;
        $error("dmem_we stayed high for two cycles");
    end

    // shortest instruction is fetch plus decode
    fetch_spacing: assert property (
        @(posedge clk) disable iff (rst) $changed(imem_addr) |=> $stable(imem_addr)
    ) else begin
        fail_count++;
        $error("imem_addr changed on two consecutive cycles");
    end

    quiet_after_reset: assert property (
        @(posedge clk) rst |=> (!dmem_we && !integer_overflow)
    ) else begin
        fail_count++;
        $error("dmem_we or integer_overflow high right after reset");
    end

endmodule

/* sim/mips_core_tb.sv */
`timescale 1ns/1ps

`include "mips_macros.svh"

module mips_core_tb;
    import mips_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int MEM_WORDS = 1 << `MIPS_MEM_AW;
    localparam logic [31:0] RAND_SEED = 32'h62021bf2;
    localparam int RANDOM_PAIRS = 20;
    // five directed programs and one short program per random pair
    localparam int RUN_COUNT = 5 + RANDOM_PAIRS;
    localparam int RUN_CYCLES = 60 * 5;

    // opcodes
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_JAL   = 6'h03;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_SLTI  = 6'h0a;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_XORI  = 6'h0e;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    // function field of the register format
    localparam logic [5:0] F_SLL  = 6'h00;
    localparam logic [5:0] F_SRL  = 6'h02;
    localparam logic [5:0] F_SRA  = 6'h03;
    localparam logic [5:0] F_SLLV = 6'h04;
    localparam logic [5:0] F_SRLV = 6'h06;
    localparam logic [5:0] F_SRAV = 6'h07;
    localparam logic [5:0] F_ADD  = 6'h20;
    localparam logic [5:0] F_ADDU = 6'h21;
    localparam logic [5:0] F_SUB  = 6'h22;
    localparam logic [5:0] F_AND  = 6'h24;
    localparam logic [5:0] F_OR   = 6'h25;
    localparam logic [5:0] F_XOR  = 6'h26;
    localparam logic [5:0] F_NOR  = 6'h27;
    localparam logic [5:0] F_SLT  = 6'h2a;
    localparam logic [5:0] F_SLTU = 6'h2b;

    logic      clk = 1'b0;
    logic      rst;
    word_t     imem_rdata;
    word_t     dmem_rdata;
    mem_addr_t imem_addr;
    mem_addr_t dmem_addr;
    word_t     dmem_wdata;
    logic      dmem_we;
    logic      integer_overflow;

    word_t     imem [MEM_WORDS];
    word_t     dmem [MEM_WORDS];
    word_t     prog [$];
    mem_addr_t exp_addr [$];
    word_t     exp_data [$];
    bit        exp_ovf [$];
    mem_addr_t cap_addr [$];
    word_t     cap_data [$];
    bit        cap_ovf [$];
    bit        ovf_pending;

    mips_core i_mips_core (
        .clk(clk), .rst(rst),
        .imem_rdata(imem_rdata), .dmem_rdata(dmem_rdata),
        .imem_addr(imem_addr), .dmem_addr(dmem_addr),
        .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
        .integer_overflow(integer_overflow)
    );

    bind mips_core mips_core_sva i_mips_core_sva (
        .clk(clk), .rst(rst), .dmem_we(dmem_we),
        .imem_addr(imem_addr), .integer_overflow(integer_overflow)
    );

    // both memories answer combinationally
    assign imem_rdata = imem[imem_addr];
    assign dmem_rdata = dmem[dmem_addr];

    always #(CLK_PERIOD / 2) clk = ~clk;

    // data memory write port and store monitor
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                dmem[mem_addr_t'(i)] <= '0;
            end
            cap_addr.delete();
            cap_data.delete();
            cap_ovf.delete();
            ovf_pending <= 1'b0;
        end else if (dmem_we) begin
            dmem[dmem_addr] <= dmem_wdata;
            cap_addr.push_back(dmem_addr);
            cap_data.push_back(dmem_wdata);
            cap_ovf.push_back(ovf_pending || integer_overflow);
            ovf_pending <= 1'b0;
        end else if (integer_overflow) begin
            ovf_pending <= 1'b1;
        end
    end

    function automatic word_t rtype(logic [5:0] funct, int rd, int rs, int rt, int sh = 0);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), funct};
    endfunction

    function automatic word_t itype(logic [5:0] op, int rt, int rs, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic word_t jtype(logic [5:0] op, int target);
        return {op, 26'(target)};
    endfunction

    // true when the exact signed result does not fit in 32 bits
    function automatic bit overflows(word_t a, word_t b, bit subtract);
        longint full;
        word_t  wrapped;
        if (subtract) begin
            full = longint'($signed(a)) - longint'($signed(b));
        end else begin
            full = longint'($signed(a)) + longint'($signed(b));
        end
        wrapped = word_t'(full);
        return full != longint'($signed(wrapped));
    endfunction

    task automatic check_value(string name, word_t actual, word_t expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, actual, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic new_program(string name);
        $display("running %s", name);
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
        exp_ovf.delete();
    endtask

    task automatic expect_store(int word, word_t data, bit ovf = 1'b0);
        exp_addr.push_back(mem_addr_t'(word));
        exp_data.push_back(data);
        exp_ovf.push_back(ovf);
    endtask

    task automatic load_const(int rd, word_t value);
        prog.push_back(itype(OP_LUI, rd, 0, int'(value[31:16])));
        prog.push_back(itype(OP_ORI, rd, rd, int'(value[15:0])));
    endtask

    // op writes r3 and the store takes it to the next free data word
    task automatic op_then_store(word_t op, word_t expected, bit ovf = 1'b0);
        prog.push_back(op);
        prog.push_back(itype(OP_SW, 3, 0, 4 * exp_addr.size()));
        expect_store(exp_addr.size(), expected, ovf);
    endtask

    task automatic load_program();
        // branch-to-self parks the core once the program is done
        prog.push_back(itype(OP_BEQ, 0, 0, -1));
        for (int i = 0; i < MEM_WORDS; i++) begin
            if (i < prog.size()) begin
                imem[mem_addr_t'(i)] = prog[i];
            end else begin
                imem[mem_addr_t'(i)] = '0;
            end
        end
    endtask

    task automatic run_program();
        @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        load_program();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        while (cap_addr.size() < exp_addr.size()) begin
            @(negedge clk);
        end
        for (int i = 0; i < exp_addr.size(); i++) begin
            check_value($sformatf("dmem_addr (store %0d)", i),
                        word_t'(cap_addr[i]), word_t'(exp_addr[i]));
            check_value($sformatf("dmem_wdata (store %0d)", i), cap_data[i], exp_data[i]);
            check_value($sformatf("integer_overflow (store %0d)", i),
                        word_t'(cap_ovf[i]), word_t'(exp_ovf[i]));
        end
    endtask

    task automatic alu_ops();
        word_t a;
        word_t b;
        a = 32'h5a5a0f3c;
        b = 32'hf0f18c21;
        new_program("ALU operations");
        load_const(1, a);
        load_const(2, b);
        op_then_store(rtype(F_ADD, 3, 1, 2), a + b);
        op_then_store(rtype(F_SUB, 3, 1, 2), a - b);
        op_then_store(rtype(F_AND, 3, 1, 2), a & b);
        op_then_store(rtype(F_OR, 3, 1, 2), a | b);
        op_then_store(rtype(F_XOR, 3, 1, 2), a ^ b);
        op_then_store(rtype(F_NOR, 3, 1, 2), ~(a | b));
        op_then_store(rtype(F_SLT, 3, 1, 2), word_t'($signed(a) < $signed(b)));
        op_then_store(rtype(F_SLTU, 3, 1, 2), word_t'(a < b));
        // logical immediates are zero-extended
        op_then_store(itype(OP_ANDI, 3, 2, 'h8f0f), b & {16'h0000, 16'h8f0f});
        op_then_store(itype(OP_ORI, 3, 2, 'h8f0f), b | {16'h0000, 16'h8f0f});
        op_then_store(itype(OP_XORI, 3, 2, 'h8f0f), b ^ {16'h0000, 16'h8f0f});
        op_then_store(itype(OP_ADDIU, 3, 1, 'h8001), a + 32'hffff8001);
        op_then_store(itype(OP_SLTI, 3, 2, 5), word_t'($signed(b) < 32'sd5));
        run_program();
    endtask

    task automatic shifts_and_lui();
        word_t v;
        v = 32'h9abcdef0;
        new_program("shifts and lui");
        load_const(1, v);
        // only the low five bits of 39 count
        prog.push_back(itype(OP_ADDIU, 2, 0, 39));
        op_then_store(rtype(F_SLL, 3, 0, 1, 4), v << 4);
        op_then_store(rtype(F_SRL, 3, 0, 1, 12), v >> 12);
        op_then_store(rtype(F_SRA, 3, 0, 1, 12), word_t'($signed(v) >>> 12));
        op_then_store(rtype(F_SLLV, 3, 2, 1), v << (39 % 32));
        op_then_store(rtype(F_SRLV, 3, 2, 1), v >> (39 % 32));
        op_then_store(rtype(F_SRAV, 3, 2, 1), word_t'($signed(v) >>> (39 % 32)));
        op_then_store(itype(OP_LUI, 3, 0, 'ha5c3), 32'ha5c30000);
        run_program();
    endtask

    task automatic load_store();
        new_program("load and store");
        prog.push_back(itype(OP_ADDIU, 1, 0, 'h1111));
        prog.push_back(itype(OP_LUI, 2, 0, 'hcafe));
        prog.push_back(itype(OP_ADDIU, 4, 0, 'h40));
        prog.push_back(itype(OP_SW, 1, 4, 0));
        expect_store(16, 32'h00001111);
        prog.push_back(itype(OP_SW, 2, 4, 8));
        expect_store(18, 32'hcafe0000);
        prog.push_back(itype(OP_SW, 1, 4, -4));
        expect_store(15, 32'h00001111);
        prog.push_back(itype(OP_LW, 5, 4, 0));
        prog.push_back(itype(OP_LW, 6, 4, 8));
        prog.push_back(rtype(F_ADDU, 3, 5, 6));
        prog.push_back(itype(OP_SW, 3, 4, 4));
        expect_store(17, 32'hcafe1111);
        prog.push_back(itype(OP_LW, 7, 4, -4));
        prog.push_back(itype(OP_SW, 7, 4, 12));
        expect_store(19, 32'h00001111);
        run_program();
    endtask

    task automatic control_flow();
        int jal_at;
        new_program("control flow");
        prog.push_back(itype(OP_ADDIU, 1, 0, 5));
        prog.push_back(itype(OP_ADDIU, 2, 0, 5));
        prog.push_back(itype(OP_ADDIU, 3, 0, 9));
        // not taken so the store still happens
        prog.push_back(itype(OP_BEQ, 3, 1, 1));
        prog.push_back(itype(OP_SW, 1, 0, 0));
        expect_store(0, 32'd5);
        // taken branch skips the store to word 1
        prog.push_back(itype(OP_BEQ, 2, 1, 1));
        prog.push_back(itype(OP_SW, 3, 0, 4));
        prog.push_back(itype(OP_SW, 2, 0, 8));
        expect_store(2, 32'd5);
        jal_at = prog.size();
        prog.push_back(jtype(OP_JAL, jal_at + 2));
        prog.push_back(itype(OP_SW, 3, 0, 12));
        prog.push_back(itype(OP_SW, `MIPS_LINK_REG, 0, 16));
        expect_store(4, word_t'(4 * jal_at + 4));
        run_program();
    endtask

    task automatic overflow_flag();
        new_program("overflow");
        load_const(1, 32'h7fffffff);
        prog.push_back(itype(OP_ADDIU, 4, 0, 'h7fff));
        prog.push_back(itype(OP_LUI, 5, 0, 'h8000));
        op_then_store(itype(OP_ADDI, 3, 1, 'h7fff), 32'h7fffffff + 32'h00007fff, 1'b1);
        op_then_store(rtype(F_ADDU, 3, 1, 4), 32'h7fffffff + 32'h00007fff, 1'b0);
        op_then_store(rtype(F_SUB, 3, 5, 4), 32'h80000000 - 32'h00007fff, 1'b1);
        run_program();
    endtask

    task automatic random_operands();
        word_t a;
        word_t b;
        for (int n = 0; n < RANDOM_PAIRS; n++) begin
            a = $urandom;
            b = $urandom;
            new_program($sformatf("random operands %0d", n));
            load_const(1, a);
            load_const(2, b);
            op_then_store(rtype(F_ADD, 3, 1, 2), a + b, overflows(a, b, 1'b0));
            op_then_store(rtype(F_SUB, 3, 1, 2), a - b, overflows(a, b, 1'b1));
            op_then_store(rtype(F_SLT, 3, 1, 2), word_t'($signed(a) < $signed(b)));
            run_program();
        end
    endtask

    initial begin
        rst = 1'b1;
        void'($urandom(RAND_SEED));
        alu_ops();
        shifts_and_lui();
        load_store();
        control_flow();
        overflow_flag();
        random_operands();
        $display("ALL TESTS PASSED");
        $finish;
    end

    // a failing bound assertion also ends the run
    initial begin
        wait (i_mips_core.i_mips_core_sva.fail_count != 0);
        $display("an assertion on the core's ports failed");
        $display("SOME TESTS FAILED");
        $fatal(1, "assertion failure");
    end

    initial begin
        #(RUN_COUNT * (RUN_CYCLES + 4) * CLK_PERIOD);
        $display("timeout: the DUT did not make its expected stores in time");
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

/* mips_core.f */
+incdir+source
source/mips_pkg.sv
source/mips_alu.sv
source/mips_regfile.sv
source/mips_datapath.sv
source/mips_control.sv
source/mips_core.sv
sim/mips_core_sva.sv
sim/mips_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= mips_core_tb
FILELIST  ?= mips_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
